//--- flist.f
+incdir+src
src/noc_pkg.sv
src/noc_input_queue.sv
src/noc_switch_alloc.sv
src/noc_router.sv
src/noc_mesh.sv
dv/noc_mesh_tb.sv

//--- dv/noc_mesh_tb.sv
// Mesh NoC testbench with traffic driver, scoreboard, checks and watchdog
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_mesh_tb;

  localparam int NODES       = `NOC_NODES;
  localparam int XN          = `NOC_X_NODES;
  localparam int CLK_PERIOD  = 8;
  localparam int MAX_HOPS    = `NOC_X_NODES + `NOC_Y_NODES - 2;
  localparam int HOP_CYCLES  = 2;    // Queue write then output register load
  // Three competitor turns per router stage with the source queue as one stage
  localparam int FAIR_BOUND  = 3 * HOP_CYCLES * (MAX_HOPS + 2);
  localparam int FAIR_DEST   = 0;
  localparam int RAND_PKTS   = 40;   // Per node and per random phase
  localparam int HOLD_PKTS   = 24;   // More than one path can store
  localparam int FAIR_PKTS   = 24;
  localparam int HOLD_CYCLES = 40;
  localparam int TOTAL_PKTS  = NODES * NODES + NODES * (2 * RAND_PKTS + HOLD_PKTS + FAIR_PKTS);
  localparam int PKT_BOUND   = NODES * HOP_CYCLES * (MAX_HOPS + 1);  // Worst cycles per packet
  localparam int DRAIN_LIMIT = PKT_BOUND * NODES * RAND_PKTS;
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * PKT_BOUND + HOLD_CYCLES + 1000;
  localparam int SINK_ON     = 0;
  localparam int SINK_RANDOM = 1;
  localparam int SINK_OFF    = 2;

  logic                           clk        = 1'b0;
  logic                           i_rst_n    = 1'b0;
  noc_pkg::packet_t [0:NODES-1]   i_data     = '0;
  logic             [0:NODES-1]   i_data_val = '0;
  logic             [0:NODES-1]   o_en;
  noc_pkg::packet_t [0:NODES-1]   o_data;
  logic             [0:NODES-1]   o_data_val;
  logic             [0:NODES-1]   i_en       = '1;  // Sinks ready

  // Sequence control set by the main process
  int   target      [0:NODES-1] = '{default: 0};  // Packets each node should have offered
  int   fixed_dest  [0:NODES-1] = '{default: 0};
  logic random_dest = 1'b0;
  int   sink_mode   = SINK_ON;
  logic lone_mode   = 1'b0;   // Latency check on
  logic fair_mode   = 1'b0;   // Wait bound check on

  // Driver state
  int   sent        [0:NODES-1] = '{default: 0};

  // Monitor state
  logic [0:NODES-1]             took      = '0;   // Handshake at the last edge
  logic [0:NODES-1]             stalled   = '0;   // Valid held against low enable
  noc_pkg::packet_t [0:NODES-1] held_data = '0;
  logic                         any_accepted = 1'b0;
  int                           cycle     = 0;
  int                           delivered_cnt = 0;
  int                           wait_cnt  [0:NODES-1] = '{default: 0};
  noc_pkg::packet_t             exp_q     [0:NODES*NODES-1][$];  // By source and destination
  int                           acc_q     [0:NODES*NODES-1][$];  // Acceptance cycles

  noc_mesh noc_mesh_inst (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Helpers
  // --------------------

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped on first error");
  endtask

  function automatic int node_of(input noc_pkg::packet_t p);
    return int'(p.dest_y) * XN + int'(p.dest_x);
  endfunction

  // Manhattan distance as XY routing takes a minimal path
  function automatic int hop_count(input int s, input int d);
    int dx;
    int dy;
    dx = (s % XN) - (d % XN);
    dy = (s / XN) - (d / XN);
    if (dx < 0) dx = -dx;
    if (dy < 0) dy = -dy;
    return dx + dy;
  endfunction

  function automatic int pending_total();
    int sum;
    sum = 0;
    for (int i = 0; i < NODES * NODES; i++) sum += exp_q[i].size();
    return sum;
  endfunction

  function automatic logic offers_open();
    logic open;
    open = (i_data_val != '0);
    for (int n = 0; n < NODES; n++) open |= (sent[n] != target[n]);
    return open;
  endfunction

  // Sequence number in the upper payload byte
  function automatic noc_pkg::packet_t make_packet(input int n);
    noc_pkg::packet_t p;
    int               d;
    d         = random_dest ? int'($urandom_range(0, NODES - 1)) : fixed_dest[n];
    p.dest_x  = `NOC_COORD_W'(d % XN);
    p.dest_y  = `NOC_COORD_W'(d / XN);
    p.src_id  = (2*`NOC_COORD_W)'(n);
    p.payload = `NOC_PAYLOAD_W'({8'(sent[n]), 8'($urandom)});
    return p;
  endfunction

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_total() != 0 || offers_open()) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_LIMIT) begin
        $display("Traffic did not drain within %0d cycles", DRAIN_LIMIT);
        abort_run();
      end
    end
    repeat (2) @(negedge clk);
    @(posedge clk);                       // Control changes land on a rising edge
  endtask

  // Driver on the falling edge
  // --------------------

  initial begin
    void'($urandom(32'h6c30));            // Stimulus seed
    forever begin
      @(negedge clk);
      if (i_rst_n) begin
        for (int n = 0; n < NODES; n++) begin
          if (i_data_val[n] && took[n]) i_data_val[n] = 1'b0;  // Taken
          if (!i_data_val[n] && sent[n] < target[n]) begin
            i_data[n]     = make_packet(n);
            i_data_val[n] = 1'b1;
            sent[n]++;
          end
          case (sink_mode)
            SINK_ON:     i_en[n] = 1'b1;
            SINK_RANDOM: i_en[n] = ($urandom_range(0, 1) == 1);
            default:     i_en[n] = 1'b0;
          endcase
        end
      end
    end
  end

  // Monitor and scoreboard on the rising edge
  // --------------------

  always @(posedge clk) begin
    int src;
    int idx;
    int lat;
    if (i_rst_n) begin
      // Idle outputs until the first packet is taken
      if (!any_accepted) begin
        assert (o_data_val == '0 && o_en == '1) else begin
          $display("Fail at %0t: o_data_val/o_en expected 0000/1111 got %b/%b",
                   $time, o_data_val, o_en);
          abort_run();
        end
      end
      for (int n = 0; n < NODES; n++) begin
        took[n] = i_data_val[n] && o_en[n];
        if (took[n]) begin
          exp_q[n * NODES + node_of(i_data[n])].push_back(i_data[n]);
          acc_q[n * NODES + node_of(i_data[n])].push_back(cycle);
          any_accepted = 1'b1;
        end
      end
      for (int d = 0; d < NODES; d++) begin
        if (stalled[d]) begin                 // Held output must not move
          assert (o_data_val[d] && o_data[d] == held_data[d]) else begin
            $display("Fail at %0t: o_data[%0d] expected %h valid 1 got %h valid %b",
                     $time, d, held_data[d], o_data[d], o_data_val[d]);
            abort_run();
          end
        end
        if (o_data_val[d] && i_en[d]) begin
          src = int'(o_data[d].src_id);
          idx = src * NODES + d;
          assert (node_of(o_data[d]) == d) else begin
            $display("Fail at %0t: o_data[%0d] destination expected %0d got %0d",
                     $time, d, d, node_of(o_data[d]));
            abort_run();
          end
          assert (exp_q[idx].size() > 0) else begin
            $display("Node %0d received a packet from node %0d that was never sent", d, src);
            abort_run();
          end
          assert (o_data[d] == exp_q[idx][0]) else begin
            $display("Fail at %0t: o_data[%0d] expected %h got %h",
                     $time, d, exp_q[idx][0], o_data[d]);
            abort_run();
          end
          lat = cycle - acc_q[idx][0];
          if (lone_mode) begin
            assert (lat == HOP_CYCLES * (hop_count(src, d) + 1)) else begin
              $display("Fail at %0t: latency node %0d to %0d expected %0d got %0d", $time,
                       src, d, HOP_CYCLES * (hop_count(src, d) + 1), lat);
              abort_run();
            end
          end
          void'(exp_q[idx].pop_front());
          void'(acc_q[idx].pop_front());
          delivered_cnt++;
          wait_cnt[src] = 0;
        end
      end
      // Every source with packets in flight keeps getting through
      for (int s = 0; s < NODES; s++) begin
        if (fair_mode && exp_q[s * NODES + FAIR_DEST].size() > 0) wait_cnt[s]++;
        else wait_cnt[s] = 0;
        assert (wait_cnt[s] <= FAIR_BOUND) else begin
          $display("Fail at %0t: wait of node %0d expected at most %0d got %0d",
                   $time, s, FAIR_BOUND, wait_cnt[s]);
          abort_run();
        end
      end
      for (int d = 0; d < NODES; d++) begin
        stalled[d]   = o_data_val[d] && !i_en[d];
        held_data[d] = o_data[d];
      end
      cycle++;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, traffic never completed", WATCHDOG_CYCLES);
    abort_run();
  end

  // Test sequence
  // --------------------

  initial begin
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;
    repeat (4) @(posedge clk);

    // Lone packet per pair in an idle mesh including self sends
    lone_mode = 1'b1;
    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        fixed_dest[s] = d;
        target[s]     = target[s] + 1;
        wait_drain();
      end
    end
    lone_mode = 1'b0;

    // Random traffic with sinks ready then toggling
    random_dest = 1'b1;
    for (int n = 0; n < NODES; n++) target[n] = target[n] + RAND_PKTS;
    wait_drain();
    sink_mode = SINK_RANDOM;
    for (int n = 0; n < NODES; n++) target[n] = target[n] + RAND_PKTS;
    wait_drain();

    // Sinks held off until every source sees o_en low
    random_dest = 1'b0;
    sink_mode   = SINK_OFF;
    for (int n = 0; n < NODES; n++) begin
      fixed_dest[n] = NODES - 1 - n;    // Opposite corner
      target[n]     = target[n] + HOLD_PKTS;
    end
    repeat (HOLD_CYCLES) @(posedge clk);
    @(negedge clk);
    assert (o_en == '0) else begin
      $display("Fail at %0t: o_en expected 0000 got %b", $time, o_en);
      abort_run();
    end
    @(posedge clk);
    sink_mode = SINK_ON;
    wait_drain();

    // All sources toward one node
    fair_mode = 1'b1;
    for (int n = 0; n < NODES; n++) begin
      fixed_dest[n] = FAIR_DEST;
      target[n]     = target[n] + FAIR_PKTS;
    end
    wait_drain();
    fair_mode = 1'b0;

    if (pending_total() == 0 && delivered_cnt == TOTAL_PKTS) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("Delivered %0d packets of %0d sent", delivered_cnt, TOTAL_PKTS);
      abort_run();
    end
  end

endmodule

//--- src/noc_mesh.sv
// 2 by 2 mesh NoC top with router array, neighbour links and edge tie-offs
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_mesh (
  input  logic                               clk,
  input  logic                               i_rst_n,

  // Node to network, valid/enable
  // --------------------
  input  noc_pkg::packet_t [0:`NOC_NODES-1] i_data,      // Packet offered by each node
  input  logic             [0:`NOC_NODES-1] i_data_val,
  output logic             [0:`NOC_NODES-1] o_en,        // Network takes the packet

  // Network to node, valid/enable
  // --------------------
  output noc_pkg::packet_t [0:`NOC_NODES-1] o_data,      // Delivered packet per node
  output logic             [0:`NOC_NODES-1] o_data_val,
  input  logic             [0:`NOC_NODES-1] i_en         // Node takes the packet
);

  localparam int X_N     = `NOC_X_NODES;
  localparam int Y_N     = `NOC_Y_NODES;
  localparam int ROUTERS = `NOC_NODES;
  localparam int DEGREE  = `NOC_DEGREE;

  // Router side of each link, rt_x[router][port]
  // Router number is y * X_N + x, same as its node
  noc_pkg::packet_t [0:ROUTERS-1][0:DEGREE-1] rt_i_data;     // Into router inputs
  logic             [0:ROUTERS-1][0:DEGREE-1] rt_i_data_val;
  logic             [0:ROUTERS-1][0:DEGREE-1] rt_o_en;       // Queue enables out
  noc_pkg::packet_t [0:ROUTERS-1][0:DEGREE-1] rt_o_data;     // From output registers
  logic             [0:ROUTERS-1][0:DEGREE-1] rt_o_data_val;
  logic             [0:ROUTERS-1][0:DEGREE-1] rt_i_en;       // Downstream enables in

  for (genvar y = 0; y < Y_N; y++) begin : gen_y
    for (genvar x = 0; x < X_N; x++) begin : gen_x
      localparam int R = y * X_N + x;

      // Local port to the node
      assign rt_i_data[R][noc_pkg::PORT_LOCAL]     = i_data[R];
      assign rt_i_data_val[R][noc_pkg::PORT_LOCAL] = i_data_val[R];
      assign rt_i_en[R][noc_pkg::PORT_LOCAL]       = i_en[R];
      assign o_en[R]       = rt_o_en[R][noc_pkg::PORT_LOCAL];
      assign o_data[R]     = rt_o_data[R][noc_pkg::PORT_LOCAL];
      assign o_data_val[R] = rt_o_data_val[R][noc_pkg::PORT_LOCAL];

      // North link pairs with the south port of router R + X_N
      if (y < Y_N - 1) begin : gen_north
        assign rt_i_data[R][noc_pkg::PORT_NORTH]     = rt_o_data[R+X_N][noc_pkg::PORT_SOUTH];
        assign rt_i_data_val[R][noc_pkg::PORT_NORTH] = rt_o_data_val[R+X_N][noc_pkg::PORT_SOUTH];
        assign rt_i_en[R][noc_pkg::PORT_NORTH]       = rt_o_en[R+X_N][noc_pkg::PORT_SOUTH];
      end else begin : gen_north_edge
        assign rt_i_data[R][noc_pkg::PORT_NORTH]     = '0;
        assign rt_i_data_val[R][noc_pkg::PORT_NORTH] = 1'b0;  // Nothing arrives
        assign rt_i_en[R][noc_pkg::PORT_NORTH]       = 1'b1;  // Never stalls
      end

      // East link pairs with the west port of router R + 1
      if (x < X_N - 1) begin : gen_east
        assign rt_i_data[R][noc_pkg::PORT_EAST]     = rt_o_data[R+1][noc_pkg::PORT_WEST];
        assign rt_i_data_val[R][noc_pkg::PORT_EAST] = rt_o_data_val[R+1][noc_pkg::PORT_WEST];
        assign rt_i_en[R][noc_pkg::PORT_EAST]       = rt_o_en[R+1][noc_pkg::PORT_WEST];
      end else begin : gen_east_edge
        assign rt_i_data[R][noc_pkg::PORT_EAST]     = '0;
        assign rt_i_data_val[R][noc_pkg::PORT_EAST] = 1'b0;
        assign rt_i_en[R][noc_pkg::PORT_EAST]       = 1'b1;
      end

      // South link pairs with the north port of router R - X_N
      if (y > 0) begin : gen_south
        assign rt_i_data[R][noc_pkg::PORT_SOUTH]     = rt_o_data[R-X_N][noc_pkg::PORT_NORTH];
        assign rt_i_data_val[R][noc_pkg::PORT_SOUTH] = rt_o_data_val[R-X_N][noc_pkg::PORT_NORTH];
        assign rt_i_en[R][noc_pkg::PORT_SOUTH]       = rt_o_en[R-X_N][noc_pkg::PORT_NORTH];
      end else begin : gen_south_edge
        assign rt_i_data[R][noc_pkg::PORT_SOUTH]     = '0;
        assign rt_i_data_val[R][noc_pkg::PORT_SOUTH] = 1'b0;
        assign rt_i_en[R][noc_pkg::PORT_SOUTH]       = 1'b1;
      end

      // West link pairs with the east port of router R - 1
      if (x > 0) begin : gen_west
        assign rt_i_data[R][noc_pkg::PORT_WEST]     = rt_o_data[R-1][noc_pkg::PORT_EAST];
        assign rt_i_data_val[R][noc_pkg::PORT_WEST] = rt_o_data_val[R-1][noc_pkg::PORT_EAST];
        assign rt_i_en[R][noc_pkg::PORT_WEST]       = rt_o_en[R-1][noc_pkg::PORT_EAST];
      end else begin : gen_west_edge
        assign rt_i_data[R][noc_pkg::PORT_WEST]     = '0;
        assign rt_i_data_val[R][noc_pkg::PORT_WEST] = 1'b0;
        assign rt_i_en[R][noc_pkg::PORT_WEST]       = 1'b1;
      end

      // Router at (x, y)
      noc_router #(
        .X_LOC      (x),
        .Y_LOC      (y)
      ) u_router (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_data     (rt_i_data[R]),      // Upstream routers and node
        .i_data_val (rt_i_data_val[R]),
        .o_en       (rt_o_en[R]),
        .o_data     (rt_o_data[R]),      // Downstream routers and node
        .o_data_val (rt_o_data_val[R]),
        .i_en       (rt_i_en[R])
      );
    end
  end

endmodule

//--- src/noc_router.sv
// Five-port mesh router with input queues, switch allocator and output registers
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_router #(
  parameter int X_LOC = 0,  // Column in the mesh
  parameter int Y_LOC = 0   // Row in the mesh
) (
  input  logic                                clk,
  input  logic                                i_rst_n,

  // Input links, valid/enable
  // --------------------
  input  noc_pkg::packet_t [0:`NOC_DEGREE-1] i_data,      // From upstream routers and node
  input  logic             [0:`NOC_DEGREE-1] i_data_val,
  output logic             [0:`NOC_DEGREE-1] o_en,        // To upstream

  // Output links, valid/enable
  // --------------------
  output noc_pkg::packet_t [0:`NOC_DEGREE-1] o_data,      // To downstream routers and node
  output logic             [0:`NOC_DEGREE-1] o_data_val,
  input  logic             [0:`NOC_DEGREE-1] i_en         // From downstream
);

  localparam int N = `NOC_DEGREE;

  // Queue heads toward the allocator
  noc_pkg::packet_t [0:N-1] head;
  logic             [0:N-1] head_val;
  logic             [0:N-1] pop;

  // Allocator toward the output registers
  noc_pkg::packet_t [0:N-1] out_data;
  logic             [0:N-1] out_load;
  logic             [0:N-1] out_free;

  // Input queues
  // --------------------

  // One FIFO per input port
  for (genvar p = 0; p < N; p++) begin : gen_queue
    noc_input_queue #(
      .DEPTH      (`NOC_QUEUE_DEPTH)
    ) u_queue (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),
      .o_head     (head[p]),
      .o_head_val (head_val[p]),
      .i_pop      (pop[p])
    );
  end

  // Switch allocation
  // --------------------

  // Empty register, or one the downstream drains this cycle
  assign out_free = ~o_data_val | i_en;

  noc_switch_alloc #(
    .X_LOC      (X_LOC),
    .Y_LOC      (Y_LOC)
  ) u_alloc (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_head     (head),
    .i_head_val (head_val),
    .i_out_free (out_free),
    .o_pop      (pop),
    .o_out_data (out_data),
    .o_out_load (out_load)
  );

  // Output registers
  // --------------------

  // Valid holds until the downstream enable takes it
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_data_val <= '0;
    end else begin
      for (int p = 0; p < N; p++) begin
        if (out_load[p])   o_data_val[p] <= 1'b1;  // New packet, back to back allowed
        else if (i_en[p])  o_data_val[p] <= 1'b0;  // Drained
      end
    end
  end

  // Data only changes on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    for (int p = 0; p < N; p++) begin
      if (out_load[p]) begin
        o_data[p] <= out_data[p];
      end
    end
  end

endmodule

//--- src/noc_switch_alloc.sv
// XY route compute, per-output round-robin switch allocator and crossbar
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_switch_alloc #(
  parameter int X_LOC = 0,  // Router column
  parameter int Y_LOC = 0   // Router row
) (
  input  logic                                clk,
  input  logic                                i_rst_n,

  // Queue heads, one per input port
  input  noc_pkg::packet_t [0:`NOC_DEGREE-1] i_head,
  input  logic             [0:`NOC_DEGREE-1] i_head_val,
  input  logic             [0:`NOC_DEGREE-1] i_out_free,  // Output register can load

  // Grants
  output logic             [0:`NOC_DEGREE-1] o_pop,       // Per input
  output noc_pkg::packet_t [0:`NOC_DEGREE-1] o_out_data,  // Per output, crossbar
  output logic             [0:`NOC_DEGREE-1] o_out_load   // Per output
);

  localparam int N  = `NOC_DEGREE;
  localparam int PW = $clog2(N);
  localparam logic [`NOC_COORD_W-1:0] X_COORD = `NOC_COORD_W'(X_LOC);
  localparam logic [`NOC_COORD_W-1:0] Y_COORD = `NOC_COORD_W'(Y_LOC);

  noc_pkg::port_e route  [0:N-1];  // Wanted output per input
  logic [0:N-1]   req    [0:N-1];  // req[output][input]
  logic [0:N-1]   gnt    [0:N-1];  // gnt[output][input]
  logic [PW-1:0]  win    [0:N-1];  // Winning input per output
  logic [PW-1:0]  rr_ptr [0:N-1];  // First input looked at

  // Route compute
  // --------------------

  // Dimension order, x first then y
  always_comb begin
    for (int i = 0; i < N; i++) begin
      if (i_head[i].dest_x > X_COORD)      route[i] = noc_pkg::PORT_EAST;
      else if (i_head[i].dest_x < X_COORD) route[i] = noc_pkg::PORT_WEST;
      else if (i_head[i].dest_y > Y_COORD) route[i] = noc_pkg::PORT_NORTH;
      else if (i_head[i].dest_y < Y_COORD) route[i] = noc_pkg::PORT_SOUTH;
      else                                 route[i] = noc_pkg::PORT_LOCAL;  // Arrived
    end
  end

  // Request matrix, each valid head asks for exactly one output
  always_comb begin
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        req[o][i] = i_head_val[i] && (int'(route[i]) == o);
      end
    end
  end

  // Arbitration
  // --------------------

  // Scan from rr_ptr, first requester wins, only for a free output
  always_comb begin
    int idx;
    for (int o = 0; o < N; o++) begin
      gnt[o]        = '0;
      win[o]        = '0;
      o_out_load[o] = 1'b0;
      for (int k = 0; k < N; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= N) idx = idx - N;       // Wrap around the port ring
        if (i_out_free[o] && req[o][idx] && !o_out_load[o]) begin
          gnt[o][idx]   = 1'b1;
          win[o]        = PW'(idx);
          o_out_load[o] = 1'b1;
        end
      end
    end
  end

  // Pop every granted head, at most one grant per input
  always_comb begin
    for (int i = 0; i < N; i++) begin
      o_pop[i] = 1'b0;
      for (int o = 0; o < N; o++) begin
        o_pop[i] = o_pop[i] | gnt[o][i];
      end
    end
  end

  // Crossbar
  always_comb begin
    for (int o = 0; o < N; o++) begin
      o_out_data[o] = i_head[win[o]];
    end
  end

  // Pointer moves one past the winner, only on a grant
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int o = 0; o < N; o++) begin
        rr_ptr[o] <= '0;
      end
    end else begin
      for (int o = 0; o < N; o++) begin
        if (o_out_load[o]) begin
          rr_ptr[o] <= (win[o] == PW'(N - 1)) ? '0 : win[o] + 1'b1;
        end
      end
    end
  end

endmodule

//--- src/noc_input_queue.sv
// Router input queue FIFO with registered not-full enable and head view
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_input_queue #(
  parameter int DEPTH = `NOC_QUEUE_DEPTH  // Entries held
) (
  input  logic             clk,
  input  logic             i_rst_n,

  // Upstream link, valid/enable
  input  noc_pkg::packet_t i_data,
  input  logic             i_data_val,
  output logic             o_en,        // Registered, room after this edge

  // Allocator side
  output noc_pkg::packet_t o_head,      // Oldest entry
  output logic             o_head_val,
  input  logic             i_pop        // Head granted this cycle
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  noc_pkg::packet_t mem [0:DEPTH-1];  // Circular storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;            // Entries currently held
  logic [CNT_W-1:0] count_next;
  logic             wr;
  logic             rd;

  // Pointer step with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr         = i_data_val & o_en;  // Only write with room
  assign rd         = i_pop & o_head_val;
  assign o_head     = mem[rd_ptr];
  assign o_head_val = (count != '0);

  // Occupancy after this edge
  always_comb begin
    case ({wr, rd})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;        // Idle or write and pop together
    endcase
  end

  // Control
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      o_en   <= 1'b1;                     // Empty queue takes a packet
    end else begin
      if (wr) wr_ptr <= ptr_inc(wr_ptr);
      if (rd) rd_ptr <= ptr_inc(rd_ptr);
      count <= count_next;
      o_en  <= (count_next < DEPTH);      // Drops once the last slot fills
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

//--- src/noc_pkg.sv
// Packet struct and router port number enum for the mesh NoC
`include "noc_consts.svh"

package noc_pkg;

  // Packet
  // --------------------

  // Single flit, routed on dest_x then dest_y
  // Source id is y * X_NODES + x of the sending node
  typedef struct packed {
    logic [`NOC_COORD_W-1:0]   dest_x;  // Destination column
    logic [`NOC_COORD_W-1:0]   dest_y;  // Destination row
    logic [2*`NOC_COORD_W-1:0] src_id;  // Sending node number
    logic [`NOC_PAYLOAD_W-1:0] payload; // Opaque node data
  } packet_t;

  // Port numbers
  // --------------------

  // Numbering shared by every router, the mesh wiring and the testbench
  // North is y+1, east is x+1
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,  // Attached node
    PORT_NORTH = 3'd1,  // Router at y+1
    PORT_EAST  = 3'd2,  // Router at x+1
    PORT_SOUTH = 3'd3,  // Router at y-1
    PORT_WEST  = 3'd4   // Router at x-1
  } port_e;

  // A link is made of
  //   a packet_t data word
  //   a valid from the sender
  //   an enable from the receiver
  // Transfer on any rising clk where valid and enable are both high

endpackage

//--- src/noc_consts.svh
// Mesh size, router degree, queue depth and packet field width macros
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Mesh shape
// --------------------

// Node columns, x runs west to east
`define NOC_X_NODES 2
// Node rows, y runs south to north
`define NOC_Y_NODES 2
// One router per node
`define NOC_NODES (`NOC_X_NODES * `NOC_Y_NODES)

// Router
// --------------------

// Local plus north, east, south, west
`define NOC_DEGREE 5
// Entries per input queue
`define NOC_QUEUE_DEPTH 4

// Packet fields
// --------------------

// Enough for a 2 wide mesh in either axis
`define NOC_COORD_W 1
// Node data carried by each flit
`define NOC_PAYLOAD_W 16

`endif
